/* verilog.f */
hw/lsu_pkg.sv
hw/lsu_agen.sv
hw/lsu_issue_buf.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
dv/tb_clkgen.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -Mdir obj_dir -o lsu_sim -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int TOTAL_OPS = 342;
    localparam int TIMEOUT   = TOTAL_OPS * 12 + 200;

    logic        clk;
    logic        rst_n;
    logic        op_valid;
    logic [31:0] ctr;
    logic [31:0] base;
    logic [31:0] imm;
    logic [31:0] store_data;
    logic [15:0] cacop_arg;
    logic        op_ready;
    logic        req_valid;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_write;
    logic [3:0]  req_wstrb;
    logic [31:0] req_cache_opcode;
    logic        req_dcache_op;
    logic        req_icache_op;
    logic        req_l2cache_op;
    logic        req_cacop_ibar;
    logic        credit_ret;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        wb_valid;
    logic [31:0] wb_data;
    logic        misalign;

    logic [31:0]  cmem [256];    // cache model storage
    logic [31:0]  ref_mem [256]; // reference view of memory
    logic [106:0] exp_req [$];
    logic [31:0]  exp_wb [$];
    logic [106:0] exp_e;
    logic [31:0]  exp_w;
    int           cr_slot [16];
    int           owed;
    int           mc;
    int           rs_due [$];
    logic [31:0]  rs_data [$];
    logic         hold;
    int           req_count;
    int           req_base;
    logic         ready_low_seen;
    logic         resp_d;
    int           mis_seen;
    int           mis_exp;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           tcyc;
    int           d;
    int           i;

    tb_clkgen #(.PERIOD(100), .RST_CYCLES(4)) u_clkgen (.clk(clk), .rst_n(rst_n));

    lsu_top UUT (
        .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .ctr(ctr), .base(base), .imm(imm),
        .store_data(store_data), .cacop_arg(cacop_arg), .op_ready(op_ready),
        .req_valid(req_valid), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_write(req_write), .req_wstrb(req_wstrb), .req_cache_opcode(req_cache_opcode),
        .req_dcache_op(req_dcache_op), .req_icache_op(req_icache_op),
        .req_l2cache_op(req_l2cache_op), .req_cacop_ibar(req_cacop_ibar),
        .credit_ret(credit_ret), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .wb_valid(wb_valid), .wb_data(wb_data), .misalign(misalign)
    );

    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] b;
        b = idx[7:0];
        return {b ^ 8'hc3, ~b, b + 8'h37, b * 8'd13};
    endfunction

    function automatic logic [31:0] make_ctr(input logic [3:0] cls, input logic [4:0] sub,
                                             input logic wr);
        return {20'b0, sub, 1'b0, wr, 1'b0, cls};
    endfunction

    // {mis, valid, addr, wdata, write, wstrb, opcode, dc, ic, l2, ci}
    function automatic logic [106:0] ref_req(input logic [31:0] c, input logic [31:0] b,
                                             input logic [31:0] im, input logic [31:0] sd,
                                             input logic [15:0] arg);
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] opcode;
        logic [3:0]  wstrb;
        logic [3:0]  fl;
        logic        valid;
        logic        mis;
        logic [4:0]  sub;
        addr   = b + im;
        sub    = c[11:7];
        wdata  = '0;
        opcode = '0;
        wstrb  = '0;
        fl     = '0;
        valid  = 1'b0;
        mis    = 1'b0;
        if (c[3:0] == 4'd5) begin
            valid = 1'b1;
            case (sub)
                5'd0, 5'd6: wstrb = 4'b0001 << addr[1:0];
                5'd1, 5'd7: begin
                    wstrb = addr[1] ? 4'b1100 : 4'b0011;
                    mis   = addr[0];
                end
                5'd2: wstrb = 4'b1111;
                5'd3: begin
                    wstrb = 4'b0001 << addr[1:0];
                    wdata[8 * addr[1:0] +: 8] = sd[7:0];
                end
                5'd4: begin
                    wstrb = addr[1] ? 4'b1100 : 4'b0011;
                    mis   = addr[0];
                    wdata[16 * addr[1] +: 16] = sd[15:0];
                end
                5'd5: begin
                    wstrb = 4'b1111;
                    wdata = sd;
                end
                5'd8: begin
                    opcode = {16'b0, arg};
                    fl[0]  = 1'b1;
                    if (arg[2:0] == 3'd1) fl[3] = 1'b1;
                    if (arg[2:0] == 3'd0) fl[2] = 1'b1;
                    if (arg[2:0] == 3'd2) fl[1] = 1'b1;
                end
                default: ;
            endcase
        end else if (c[3:0] == 4'd6) begin
            valid = 1'b1;
            wstrb = 4'b1111;
            if (sub == 5'd1) wdata = sd; // sc.w stores the full word
        end else if (c[3:0] == 4'd9) begin
            valid  = 1'b1;
            opcode = 32'h8000_0000;
            fl     = 4'b0101;
        end
        if (mis) valid = 1'b0;
        return {mis, valid, addr, wdata, c[5], wstrb, opcode, fl};
    endfunction

    function automatic logic [31:0] ref_wb(input logic [31:0] word, input logic [4:0] sub,
                                           input logic [1:0] off);
        logic [7:0]  by;
        logic [15:0] hw;
        by = word[8 * off +: 8];
        hw = word[16 * off[1] +: 16];
        case (sub)
            5'd0:    return {{24{by[7]}}, by};
            5'd6:    return {24'b0, by};
            5'd1:    return {{16{hw[15]}}, hw};
            5'd7:    return {16'b0, hw};
            default: return word;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic send_op(input logic [31:0] c, input logic [31:0] b, input logic [31:0] im,
                           input logic [31:0] sd, input logic [15:0] arg);
        logic [106:0] r;
        logic [7:0]   idx;
        logic [4:0]   sub;
        r   = ref_req(c, b, im, sd, arg);
        idx = r[82:75];
        sub = (c[3:0] == 4'd6) ? 5'd2 : c[11:7];
        if (r[106]) begin
            mis_exp++;
        end else if (r[105]) begin
            exp_req.push_back(r);
            if (r[39:36] != 4'b0 && !r[0]) begin
                if (r[40]) begin
                    for (int k = 0; k < 4; k++)
                        if (r[36 + k]) ref_mem[idx][8 * k +: 8] = r[41 + 8 * k +: 8];
                end else begin
                    exp_wb.push_back(ref_wb(ref_mem[idx], sub, r[74:73]));
                end
            end
        end
        op_valid   = 1'b1;
        ctr        = c;
        base       = b;
        imm        = im;
        store_data = sd;
        cacop_arg  = arg;
        @(posedge clk);
        while (!op_ready) @(posedge clk);
        #10 op_valid = 1'b0;
        check("misalign", 32'(misalign), 32'(r[106])); // pulse one cycle after transfer
    endtask

    task automatic mem_op(input logic [3:0] cls, input logic [4:0] sub, input logic wr,
                          input logic [31:0] addr, input logic [31:0] sd);
        send_op(make_ctr(cls, sub, wr), addr - 32'd8, 32'd8, sd, 16'h0);
    endtask

    task automatic rand_op();
        int          k;
        int          idx;
        logic [1:0]  off;
        logic [31:0] addr;
        logic [31:0] im;
        k   = $urandom_range(0, 13);
        idx = $urandom_range(0, 255);
        off = 2'($urandom_range(0, 3));
        im  = 32'($urandom_range(0, 64)) - 32'd32;
        if (k == 2 || k == 7 || k >= 10) off = 2'b00;
        if (k == 1 || k == 4 || k == 6) off[0] = 1'b0;
        if (k == 13) off[0] = 1'b1;
        addr = idx * 4 + off;
        case (k)
            0:  send_op(make_ctr(4'd5, 5'd0, 1'b0), addr - im, im, $urandom, 16'h0);
            1:  send_op(make_ctr(4'd5, 5'd1, 1'b0), addr - im, im, $urandom, 16'h0);
            2:  send_op(make_ctr(4'd5, 5'd2, 1'b0), addr - im, im, $urandom, 16'h0);
            3:  send_op(make_ctr(4'd5, 5'd6, 1'b0), addr - im, im, $urandom, 16'h0);
            4:  send_op(make_ctr(4'd5, 5'd7, 1'b0), addr - im, im, $urandom, 16'h0);
            5:  send_op(make_ctr(4'd5, 5'd3, 1'b1), addr - im, im, $urandom, 16'h0);
            6:  send_op(make_ctr(4'd5, 5'd4, 1'b1), addr - im, im, $urandom, 16'h0);
            7:  send_op(make_ctr(4'd5, 5'd5, 1'b1), addr - im, im, $urandom, 16'h0);
            8:  send_op(make_ctr(4'd5, 5'd8, 1'b0), addr - im, im, $urandom,
                        {13'($urandom), 3'($urandom_range(0, 2))});
            9:  send_op(make_ctr(4'd9, 5'd0, 1'b0), addr - im, im, $urandom, 16'h0);
            10: send_op(make_ctr(4'd6, 5'd0, 1'b0), addr - im, im, $urandom, 16'h0);
            11: send_op(make_ctr(4'd6, 5'd1, 1'b1), addr - im, im, $urandom, 16'h0);
            12: send_op(make_ctr(4'd3, 5'd2, 1'b0), addr - im, im, $urandom, 16'h0);
            default: send_op(make_ctr(4'd5, ($urandom_range(0, 1) == 0) ? 5'd1 : 5'd7,
                                      1'b0), addr - im, im, $urandom, 16'h0);
        endcase
    endtask

    task automatic end_test(input string name, input int err_before);
        while (exp_req.size() != 0 || exp_wb.size() != 0) @(posedge clk);
        repeat (6) @(posedge clk);
        #10;
        check("misalign_count", 32'(mis_seen), 32'(mis_exp));
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    // cache model: credits, stores through strobes, in-order load answers
    always @(posedge clk) begin
        if (rst_n) begin
            mc++;
            owed += cr_slot[mc % 16];
            cr_slot[mc % 16] = 0;
            if (req_valid) begin
                req_count++;
                d = $urandom_range(1, 4);
                cr_slot[(mc + d) % 16]++;
                if (req_write && !req_cacop_ibar) begin
                    for (int k = 0; k < 4; k++)
                        if (req_wstrb[k]) cmem[req_addr[9:2]][8 * k +: 8] = req_wdata[8 * k +: 8];
                end else if (!req_cacop_ibar && req_wstrb != 4'b0) begin
                    rs_due.push_back(mc + $urandom_range(1, 3));
                    rs_data.push_back(cmem[req_addr[9:2]]);
                end
            end
        end
        #10;
        credit_ret = 1'b0;
        resp_valid = 1'b0;
        if (rst_n && !hold && owed > 0) begin
            credit_ret = 1'b1;
            owed--;
        end
        if (rst_n && rs_due.size() != 0 && rs_due[0] <= mc) begin
            resp_valid = 1'b1;
            resp_rdata = rs_data.pop_front();
            void'(rs_due.pop_front());
        end
    end

    // compare process
    always @(posedge clk) begin
        if (rst_n) begin
            if (!op_ready) ready_low_seen = 1'b1;
            if (misalign) mis_seen++;
            check("wb_valid", 32'(wb_valid), 32'(resp_d));
            resp_d = resp_valid;
            if (req_valid) begin
                if (exp_req.size() == 0) begin
                    $display("request to address 0x%h was not expected", req_addr);
                    errors++;
                end else begin
                    exp_e = exp_req.pop_front();
                    check("req_addr", req_addr, exp_e[104:73]);
                    check("req_wdata", req_wdata, exp_e[72:41]);
                    check("req_write", 32'(req_write), 32'(exp_e[40]));
                    check("req_wstrb", 32'(req_wstrb), 32'(exp_e[39:36]));
                    check("req_cache_opcode", req_cache_opcode, exp_e[35:4]);
                    check("req_dcache_op", 32'(req_dcache_op), 32'(exp_e[3]));
                    check("req_icache_op", 32'(req_icache_op), 32'(exp_e[2]));
                    check("req_l2cache_op", 32'(req_l2cache_op), 32'(exp_e[1]));
                    check("req_cacop_ibar", 32'(req_cacop_ibar), 32'(exp_e[0]));
                end
            end
            if (wb_valid) begin
                if (exp_wb.size() == 0) begin
                    $display("write-back of 0x%h was not expected", wb_data);
                    errors++;
                end else begin
                    exp_w = exp_wb.pop_front();
                    check("wb_data", wb_data, exp_w);
                end
            end
        end
    end

    always @(posedge clk) begin
        tcyc++;
        if (tcyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int e0;
        void'($urandom(25));
        op_valid       = 1'b0;
        ctr            = '0;
        base           = '0;
        imm            = '0;
        store_data     = '0;
        cacop_arg      = '0;
        credit_ret     = 1'b0;
        resp_valid     = 1'b0;
        resp_rdata     = '0;
        resp_d         = 1'b0;
        ready_low_seen = 1'b0;
        hold           = 1'b0;
        owed           = 0;
        mc             = 0;
        errors         = 0;
        for (i = 0; i < 256; i++) begin
            cmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (i = 0; i < 16; i++) cr_slot[i] = 0;
        @(posedge rst_n);
        @(posedge clk);
        #10;
        check("req_valid", 32'(req_valid), 32'd0);
        check("wb_valid", 32'(wb_valid), 32'd0);
        check("misalign", 32'(misalign), 32'd0);
        check("op_ready", 32'(op_ready), 32'd1);
        check("req_icache_op", 32'(req_icache_op), 32'd0);
        check("req_dcache_op", 32'(req_dcache_op), 32'd0);
        check("req_l2cache_op", 32'(req_l2cache_op), 32'd0);
        check("req_cacop_ibar", 32'(req_cacop_ibar), 32'd0);

        e0 = errors;
        for (i = 0; i < 4; i++) mem_op(4'd5, 5'd3, 1'b1, 32'd64 + i, 32'h1234_5600 + i * 17);
        mem_op(4'd5, 5'd4, 1'b1, 32'd68, 32'h0000_8001);
        mem_op(4'd5, 5'd4, 1'b1, 32'd70, 32'h0000_7ffe);
        mem_op(4'd5, 5'd5, 1'b1, 32'd72, 32'hdead_beef);
        for (i = 0; i < 3; i++) mem_op(4'd5, 5'd2, 1'b0, 32'd64 + i * 4, 32'h0);
        end_test("stores", e0);

        e0 = errors;
        for (i = 0; i < 4; i++) mem_op(4'd5, 5'd0, 1'b0, 32'd80 + i, 32'h0);
        for (i = 0; i < 4; i++) mem_op(4'd5, 5'd6, 1'b0, 32'd84 + i, 32'h0);
        for (i = 0; i < 2; i++) mem_op(4'd5, 5'd1, 1'b0, 32'd88 + i * 2, 32'h0);
        for (i = 0; i < 2; i++) mem_op(4'd5, 5'd7, 1'b0, 32'd92 + i * 2, 32'h0);
        mem_op(4'd5, 5'd2, 1'b0, 32'd96, 32'h0);
        end_test("loads", e0);

        e0 = errors;
        mem_op(4'd5, 5'd1, 1'b0, 32'd101, 32'h0);
        mem_op(4'd5, 5'd7, 1'b0, 32'd103, 32'h0);
        mem_op(4'd5, 5'd4, 1'b1, 32'd105, 32'hffff_ffff);
        mem_op(4'd5, 5'd2, 1'b0, 32'd104, 32'h0);
        end_test("misalign", e0);

        e0 = errors;
        for (i = 0; i < 3; i++)
            send_op(make_ctr(4'd5, 5'd8, 1'b0), 32'd200, 32'd0, 32'h0, 16'h5a50 + i);
        send_op(make_ctr(4'd9, 5'd0, 1'b0), 32'd0, 32'd0, 32'h0, 16'h0);
        mem_op(4'd6, 5'd1, 1'b1, 32'd120, 32'hcafe_f00d); // sc.w
        mem_op(4'd6, 5'd0, 1'b0, 32'd120, 32'h0);         // ll.w
        mem_op(4'd5, 5'd2, 1'b0, 32'd120, 32'h0);
        end_test("cacop_ibar_atomic", e0);

        e0 = errors;
        ready_low_seen = 1'b0;
        hold = 1'b1;
        req_base = req_count;
        fork
            begin
                for (int k = 0; k < 8; k++)
                    mem_op(4'd5, (k % 2 == 0) ? 5'd5 : 5'd2, (k % 2 == 0),
                           32'd160 + 4 * (k / 2), 32'h0bad_0000 + k);
            end
            begin
                repeat (40) @(posedge clk);
                #20;
                if (req_count - req_base > 4) begin
                    $display("more requests than credits went out while credits were held");
                    errors++;
                end
                if (!ready_low_seen) begin
                    $display("op_ready never fell while credits were held");
                    errors++;
                end
                hold = 1'b0;
            end
        join
        end_test("backpressure", e0);

        e0 = errors;
        for (i = 0; i < 300; i++) rand_op();
        end_test("random", e0);

        $display("tests %0d, failed tests %0d, failed checks %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1; // released off the edge like other stimulus
    end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         op_valid,
    input  wire  [31:0] ctr,
    input  wire  [31:0] base,
    input  wire  [31:0] imm,
    input  wire  [31:0] store_data,
    input  wire  [15:0] cacop_arg,
    output logic        op_ready,
    output logic        req_valid,
    output logic [31:0] req_addr,
    output logic [31:0] req_wdata,
    output logic        req_write,
    output logic [3:0]  req_wstrb,
    output logic [31:0] req_cache_opcode,
    output logic        req_dcache_op,
    output logic        req_icache_op,
    output logic        req_l2cache_op,
    output logic        req_cacop_ibar,
    input  wire         credit_ret,
    input  wire         resp_valid,
    input  wire  [31:0] resp_rdata,
    output logic        wb_valid,
    output logic [31:0] wb_data,
    output logic        misalign
);

    logic        op_fire;
    logic        a_valid;
    logic [31:0] a_addr;
    logic [31:0] a_wdata;
    logic        a_write;
    logic [3:0]  a_wstrb;
    logic [4:0]  a_sub;
    logic        a_is_load;
    logic [31:0] a_cache_opcode;
    logic        a_dcache_op;
    logic        a_icache_op;
    logic        a_l2cache_op;
    logic        a_cacop_ibar;
    logic        ld_push;
    logic [4:0]  ld_sub;
    logic [1:0]  ld_off;

    assign op_fire = op_valid && op_ready; // execute handshake

    lsu_agen u_agen (
        .clk(clk), .rst_n(rst_n), .op_valid(op_fire),
        .ctr(ctr), .base(base), .imm(imm), .store_data(store_data), .cacop_arg(cacop_arg),
        .a_valid(a_valid), .a_addr(a_addr), .a_wdata(a_wdata), .a_write(a_write),
        .a_wstrb(a_wstrb), .a_sub(a_sub), .a_is_load(a_is_load),
        .a_cache_opcode(a_cache_opcode), .a_dcache_op(a_dcache_op),
        .a_icache_op(a_icache_op), .a_l2cache_op(a_l2cache_op),
        .a_cacop_ibar(a_cacop_ibar), .misalign(misalign)
    );

    lsu_issue_buf u_issue_buf (
        .clk(clk), .rst_n(rst_n),
        .a_valid(a_valid), .a_addr(a_addr), .a_wdata(a_wdata), .a_write(a_write),
        .a_wstrb(a_wstrb), .a_sub(a_sub), .a_is_load(a_is_load),
        .a_cache_opcode(a_cache_opcode), .a_dcache_op(a_dcache_op),
        .a_icache_op(a_icache_op), .a_l2cache_op(a_l2cache_op),
        .a_cacop_ibar(a_cacop_ibar), .credit_ret(credit_ret), .op_ready(op_ready),
        .req_valid(req_valid), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_write(req_write), .req_wstrb(req_wstrb), .req_cache_opcode(req_cache_opcode),
        .req_dcache_op(req_dcache_op), .req_icache_op(req_icache_op),
        .req_l2cache_op(req_l2cache_op), .req_cacop_ibar(req_cacop_ibar),
        .ld_push(ld_push), .ld_sub(ld_sub), .ld_off(ld_off)
    );

    lsu_load_align u_load_align (
        .clk(clk), .rst_n(rst_n),
        .ld_push(ld_push), .ld_sub(ld_sub), .ld_off(ld_off),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .wb_valid(wb_valid), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* hw/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         ld_push,
    input  wire  [4:0]  ld_sub,
    input  wire  [1:0]  ld_off,
    input  wire         resp_valid,
    input  wire  [31:0] resp_rdata,
    output logic        wb_valid,
    output logic [31:0] wb_data
);

    logic [lsu_pkg::PEND_W-1:0] pend [lsu_pkg::CREDITS];
    logic [lsu_pkg::PTR_W-1:0]  wr_ptr;
    logic [lsu_pkg::PTR_W-1:0]  rd_ptr;
    logic [lsu_pkg::CNT_W-1:0]  count;
    logic [4:0]                 head_sub;
    logic [1:0]                 head_off;
    logic [31:0]                shifted;
    logic [31:0]                ext;

    assign {head_sub, head_off} = pend[rd_ptr];
    assign shifted = resp_rdata >> {head_off, 3'b000}; // wanted lane down to bit 0

    always_comb begin
        case (lsu_pkg::mem_sub_e'(head_sub))
            lsu_pkg::SUB_LD_B:  ext = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::SUB_LD_BU: ext = {24'b0, shifted[7:0]};
            lsu_pkg::SUB_LD_H:  ext = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::SUB_LD_HU: ext = {16'b0, shifted[15:0]};
            default:            ext = resp_rdata; // ld.w and ll.w
        endcase
    end

    always_ff @(posedge clk) begin
        if (ld_push)
            pend[wr_ptr] <= {ld_sub, ld_off};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wb_valid <= 1'b0;
        end else begin
            if (ld_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (resp_valid)
                rd_ptr <= rd_ptr + 1'b1;
            if (ld_push && !resp_valid)
                count <= count + 1'b1;
            else if (!ld_push && resp_valid)
                count <= count - 1'b1;
            wb_valid <= resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid)
            wb_data <= ext;
    end

    resp_has_load: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> count != '0)
        else $error("load response with no pending load");

    pend_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        ld_push && !resp_valid |-> count != lsu_pkg::CREDITS)
        else $error("pending load queue overflow");

endmodule

`default_nettype wire

/* hw/lsu_issue_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_buf (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         a_valid,
    input  wire  [31:0] a_addr,
    input  wire  [31:0] a_wdata,
    input  wire         a_write,
    input  wire  [3:0]  a_wstrb,
    input  wire  [4:0]  a_sub,
    input  wire         a_is_load,
    input  wire  [31:0] a_cache_opcode,
    input  wire         a_dcache_op,
    input  wire         a_icache_op,
    input  wire         a_l2cache_op,
    input  wire         a_cacop_ibar,
    input  wire         credit_ret,
    output logic        op_ready,
    output logic        req_valid,
    output logic [31:0] req_addr,
    output logic [31:0] req_wdata,
    output logic        req_write,
    output logic [3:0]  req_wstrb,
    output logic [31:0] req_cache_opcode,
    output logic        req_dcache_op,
    output logic        req_icache_op,
    output logic        req_l2cache_op,
    output logic        req_cacop_ibar,
    output logic        ld_push,
    output logic [4:0]  ld_sub,
    output logic [1:0]  ld_off
);

    logic [lsu_pkg::ENTRY_W-1:0] mem [lsu_pkg::CREDITS];
    logic [lsu_pkg::PTR_W-1:0]   wr_ptr;
    logic [lsu_pkg::PTR_W-1:0]   rd_ptr;
    logic [lsu_pkg::CNT_W-1:0]   count;
    logic [lsu_pkg::CNT_W-1:0]   count_nxt;
    logic [lsu_pkg::CNT_W-1:0]   credits;
    logic                        h_write;
    logic                        h_load;
    logic                        h_dc;
    logic                        h_ic;
    logic                        h_l2;
    logic                        h_ci;

    assign {req_addr, req_wdata, req_cache_opcode, h_write, req_wstrb, ld_sub, h_load,
            h_dc, h_ic, h_l2, h_ci} = mem[rd_ptr];

    assign req_valid      = (count != '0) && (credits != '0);
    assign req_write      = req_valid && h_write;
    assign req_dcache_op  = req_valid && h_dc;
    assign req_icache_op  = req_valid && h_ic;
    assign req_l2cache_op = req_valid && h_l2;
    assign req_cacop_ibar = req_valid && h_ci;
    assign ld_push        = req_valid && h_load;
    assign ld_off         = req_addr[1:0];

    always_comb begin
        count_nxt = count;
        if (a_valid && !req_valid)
            count_nxt = count + 1'b1;
        else if (!a_valid && req_valid)
            count_nxt = count - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (a_valid)
            mem[wr_ptr] <= {a_addr, a_wdata, a_cache_opcode, a_write, a_wstrb, a_sub, a_is_load,
                            a_dcache_op, a_icache_op, a_l2cache_op, a_cacop_ibar};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credits  <= lsu_pkg::CNT_W'(lsu_pkg::CREDITS);
            op_ready <= 1'b1;
        end else begin
            if (a_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (req_valid)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_nxt;
            if (req_valid && !credit_ret)
                credits <= credits - 1'b1;
            else if (!req_valid && credit_ret)
                credits <= credits + 1'b1;
            op_ready <= (count_nxt <= lsu_pkg::CREDITS - 2); // room for agen slot too
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= lsu_pkg::CREDITS)
        else $error("cache returned more credits than granted");

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid |-> count != lsu_pkg::CREDITS)
        else $error("agen wrote into a full issue FIFO");

endmodule

`default_nettype wire

/* hw/lsu_agen.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agen (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         op_valid,
    input  wire  [31:0] ctr,
    input  wire  [31:0] base,
    input  wire  [31:0] imm,
    input  wire  [31:0] store_data,
    input  wire  [15:0] cacop_arg,
    output logic        a_valid,
    output logic [31:0] a_addr,
    output logic [31:0] a_wdata,
    output logic        a_write,
    output logic [3:0]  a_wstrb,
    output logic [4:0]  a_sub,
    output logic        a_is_load,
    output logic [31:0] a_cache_opcode,
    output logic        a_dcache_op,
    output logic        a_icache_op,
    output logic        a_l2cache_op,
    output logic        a_cacop_ibar,
    output logic        misalign
);

    lsu_pkg::mem_class_e cls;
    lsu_pkg::mem_sub_e   sub;
    lsu_pkg::mem_sub_e   eff_sub;
    lsu_pkg::cache_tgt_e tgt;

    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] opcode;
    logic        is_mem;
    logic        is_load;
    logic        half_bad;
    logic        dc_op;
    logic        ic_op;
    logic        l2_op;
    logic        cop_ibar;
    logic        take;

    assign cls  = lsu_pkg::mem_class_e'(ctr[3:0]);
    assign sub  = lsu_pkg::mem_sub_e'(ctr[11:7]);
    assign tgt  = lsu_pkg::cache_tgt_e'(cacop_arg[2:0]);
    assign addr = base + imm;

    always_comb begin
        is_mem   = 1'b0;
        is_load  = 1'b0;
        half_bad = 1'b0;
        eff_sub  = sub;
        wdata    = '0;
        wstrb    = '0;
        opcode   = '0;
        dc_op    = 1'b0;
        ic_op    = 1'b0;
        l2_op    = 1'b0;
        cop_ibar = 1'b0;
        case (cls)
            lsu_pkg::CLS_MEM: begin
                is_mem = 1'b1;
                case (sub)
                    lsu_pkg::SUB_LD_B, lsu_pkg::SUB_LD_BU: begin
                        is_load = 1'b1;
                        wstrb   = 4'b0001 << addr[1:0];
                    end
                    lsu_pkg::SUB_LD_H, lsu_pkg::SUB_LD_HU: begin
                        is_load  = 1'b1;
                        wstrb    = addr[1] ? 4'b1100 : 4'b0011;
                        half_bad = addr[0];
                    end
                    lsu_pkg::SUB_LD_W: begin
                        is_load = 1'b1;
                        wstrb   = 4'b1111;
                    end
                    lsu_pkg::SUB_ST_B: begin
                        wstrb = 4'b0001 << addr[1:0];
                        wdata = {24'b0, store_data[7:0]} << {addr[1:0], 3'b000};
                    end
                    lsu_pkg::SUB_ST_H: begin
                        wstrb    = addr[1] ? 4'b1100 : 4'b0011;
                        wdata    = {16'b0, store_data[15:0]} << {addr[1], 4'b0000};
                        half_bad = addr[0];
                    end
                    lsu_pkg::SUB_ST_W: begin
                        wstrb = 4'b1111;
                        wdata = store_data;
                    end
                    lsu_pkg::SUB_CACOP: begin
                        case (tgt)
                            lsu_pkg::TGT_ICACHE: ic_op = 1'b1;
                            lsu_pkg::TGT_DCACHE: dc_op = 1'b1;
                            lsu_pkg::TGT_L2:     l2_op = 1'b1;
                            default: ;
                        endcase
                        opcode   = {16'b0, cacop_arg};
                        cop_ibar = 1'b1;
                    end
                    default: ;
                endcase
            end
            lsu_pkg::CLS_ATOMIC: begin
                is_mem = 1'b1;
                if (sub == lsu_pkg::SUB_LL) begin
                    is_load = 1'b1;
                    wstrb   = 4'b1111;
                    eff_sub = lsu_pkg::SUB_LD_W; // aligner sees a plain word
                end else if (sub == lsu_pkg::SUB_SC) begin
                    wstrb   = 4'b1111;
                    wdata   = store_data;
                    eff_sub = lsu_pkg::SUB_ST_W;
                end
            end
            lsu_pkg::CLS_IBAR: begin
                is_mem   = 1'b1;
                opcode   = lsu_pkg::IBAR_OPCODE;
                ic_op    = 1'b1;
                cop_ibar = 1'b1;
            end
            default: ;
        endcase
    end

    assign take = op_valid && is_mem && !half_bad;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_valid      <= 1'b0;
            misalign     <= 1'b0;
            a_dcache_op  <= 1'b0;
            a_icache_op  <= 1'b0;
            a_l2cache_op <= 1'b0;
            a_cacop_ibar <= 1'b0;
        end else begin
            a_valid      <= take;
            misalign     <= op_valid && half_bad; // dropped, never enqueued
            a_dcache_op  <= take && dc_op;
            a_icache_op  <= take && ic_op;
            a_l2cache_op <= take && l2_op;
            a_cacop_ibar <= take && cop_ibar;
        end
    end

    always_ff @(posedge clk) begin
        a_addr         <= addr;
        a_wdata        <= wdata;
        a_write        <= ctr[5];
        a_wstrb        <= wstrb;
        a_sub          <= eff_sub;
        a_is_load      <= is_load;
        a_cache_opcode <= opcode;
    end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int ADDR_W  = 32;
    localparam int CREDITS = 4;
    localparam int PTR_W   = $clog2(CREDITS);
    localparam int CNT_W   = $clog2(CREDITS + 1);

    // addr, wdata and opcode words plus 15 control bits
    localparam int ENTRY_W = 3 * ADDR_W + 15;
    localparam int PEND_W  = 7; // subtype and byte offset

    typedef enum logic [3:0] {
        CLS_MEM    = 4'd5,
        CLS_ATOMIC = 4'd6,
        CLS_IBAR   = 4'd9
    } mem_class_e;

    typedef enum logic [4:0] {
        SUB_LD_B  = 5'd0,
        SUB_LD_H  = 5'd1,
        SUB_LD_W  = 5'd2,
        SUB_ST_B  = 5'd3,
        SUB_ST_H  = 5'd4,
        SUB_ST_W  = 5'd5,
        SUB_LD_BU = 5'd6,
        SUB_LD_HU = 5'd7,
        SUB_CACOP = 5'd8
    } mem_sub_e;

    // atomic class reuses the low subtype codes
    localparam mem_sub_e SUB_LL = SUB_LD_B;
    localparam mem_sub_e SUB_SC = SUB_LD_H;

    typedef enum logic [2:0] {
        TGT_ICACHE = 3'd0,
        TGT_DCACHE = 3'd1,
        TGT_L2     = 3'd2
    } cache_tgt_e;

    localparam logic [ADDR_W-1:0] IBAR_OPCODE = {1'b1, {(ADDR_W - 1){1'b0}}};

endpackage

`default_nettype wire
